//--- mem_packet_pkg.sv
package mem_packet_pkg;

    //////////////////////////////
    // Client side identifiers
    //////////////////////////////

    localparam int num_ports = 2;                   // Clients served by the front end

    typedef logic       port_id_t;                  // Also selects bit 31 of the word address
    typedef logic [7:0] tag_t;                      // Per-port sequence number, wraps

    //////////////////////////////
    // Packets
    //////////////////////////////

    typedef struct packed
    {
        logic        write;
        port_id_t    port;
        tag_t        tag;
        logic [3:0]  byte_sel;                      // One bit per byte lane of data
        logic [31:0] addr;                          // Word address
        logic [31:0] data;
    } mem_request_t;

    // A write returns its own data so completions look alike for both kinds
    typedef struct packed
    {
        logic        write;
        port_id_t    port;
        tag_t        tag;
        logic [31:0] addr;
        logic [31:0] data;                          // Read data or echoed write data
    } mem_response_t;

endpackage

//--- wb_bus_pkg.sv
package wb_bus_pkg;

    localparam int wb_addr_width = 32;
    localparam int wb_data_width = 32;
    localparam int wb_sel_width  = 4;

    // Master to slave, classic cycles only
    typedef struct packed
    {
        logic                      cyc;
        logic                      stb;
        logic                      we;
        logic [wb_addr_width-1:0]  adr;
        logic [wb_data_width-1:0]  dat;
        logic [wb_sel_width-1:0]   sel;
    } wb_m2s_t;

    typedef struct packed
    {
        logic                      ack;
        logic [wb_data_width-1:0]  dat;
    } wb_s2m_t;

endpackage

//--- single_port_lutram.sv
module single_port_lutram
#(
    parameter int entry_width = 64
)
(
    input  logic                             clk_in,
    input  logic                             reset_in,

    input  logic [(entry_width + 7) / 8 - 1:0] write_mask,
    input  logic [entry_width-1:0]           write_entry_in,
    output logic [entry_width-1:0]           read_entry_out
);

    logic [entry_width-1:0] mem_word;

    // Each bit follows the mask bit of its byte lane
    always_ff @(posedge clk_in)
    begin
        for (int i = 0; i < entry_width; i++)
        begin
            if (~reset_in & write_mask[i / 8])      // Writes are held off during reset
            begin
                mem_word[i] <= write_entry_in[i];
            end
        end
    end

    assign read_entry_out = mem_word;               // Asynchronous read

endmodule

//--- fifo_queue.sv
module fifo_queue
#(
    parameter type entry_t          = logic [63:0],
    parameter int  queue_size       = 16,
    parameter int  queue_ptr_width  = 4,
    parameter      storage_type     = "LUTRAM"      // FlipFlop or LUTRAM
)
(
    input  logic    clk_in,
    input  logic    reset_in,

    output logic    is_empty_out,
    output logic    is_full_out,

    input  entry_t  request_in,
    input  logic    request_valid_in,
    output logic    issue_ack_out,

    output entry_t  request_out,
    output logic    request_valid_out,
    input  logic    issue_ack_in
);

    localparam int entry_width = $bits(entry_t);
    localparam int mask_len    = (entry_width + 7) / 8;
    localparam logic [queue_ptr_width-1:0] last_ptr = queue_ptr_width'(queue_size - 1);

    wire  [queue_size-1:0]      write_qualified;
    wire  [queue_size-1:0]      read_qualified;
    wire  [queue_size-1:0]      entry_valid;
    entry_t                     fifo_entry [queue_size];

    logic [queue_ptr_width-1:0] write_ptr;
    logic [queue_ptr_width-1:0] read_ptr;

    assign is_full_out  = &entry_valid;
    assign is_empty_out = ~|entry_valid;

    //////////////////////////////
    // Pointers and handshake
    //////////////////////////////

    always_ff @(posedge clk_in, posedge reset_in)
    begin
        if (reset_in)
        begin
            write_ptr         <= '0;
            read_ptr          <= '0;
            issue_ack_out     <= 1'b0;
            request_out       <= '0;
            request_valid_out <= 1'b0;
        end
        else
        begin
            issue_ack_out <= |write_qualified;      // One cycle after the write is taken
            if (|write_qualified)
            begin
                write_ptr <= (write_ptr == last_ptr) ? '0 : write_ptr + 1'b1;
            end

            if (|read_qualified)
            begin
                read_ptr          <= (read_ptr == last_ptr) ? '0 : read_ptr + 1'b1;
                request_out       <= '0;
                request_valid_out <= 1'b0;          // Gap of one cycle after every pop
            end
            else if (entry_valid[read_ptr])
            begin
                request_out       <= fifo_entry[read_ptr];
                request_valid_out <= 1'b1;
            end
            else
            begin
                request_out       <= '0;
                request_valid_out <= 1'b0;
            end
        end
    end

    //////////////////////////////
    // Entries
    //////////////////////////////

    for (genvar gen = 0; gen < queue_size; gen++)
    begin : g_entry
        logic valid_q;

        assign entry_valid[gen] = valid_q;

        // A full queue still takes a write into the slot that is popped in the same cycle
        assign write_qualified[gen] =
            (~is_full_out | (issue_ack_in & is_full_out & (read_ptr == queue_ptr_width'(gen))))
            & ~issue_ack_out & request_valid_in & (write_ptr == queue_ptr_width'(gen));

        assign read_qualified[gen] =
            ~is_empty_out & issue_ack_in & valid_q & (read_ptr == queue_ptr_width'(gen));

        always_ff @(posedge clk_in, posedge reset_in)
        begin
            if (reset_in)
            begin
                valid_q <= 1'b0;
            end
            else if (write_qualified[gen])
            begin
                valid_q <= 1'b1;                    // Write wins over a pop of the same slot
            end
            else if (read_qualified[gen])
            begin
                valid_q <= 1'b0;
            end
        end

        if (storage_type == "LUTRAM")
        begin : g_lutram
            single_port_lutram
            #(
                .entry_width    (entry_width)
            )
            i_single_port_lutram
            (
                .clk_in         (clk_in),
                .reset_in       (reset_in),
                .write_mask     ({mask_len{write_qualified[gen]}}),
                .write_entry_in (request_in),
                .read_entry_out (fifo_entry[gen])
            );
        end
        else
        begin : g_flip_flop
            entry_t entry_q;

            always_ff @(posedge clk_in)
            begin
                if (write_qualified[gen])
                begin
                    entry_q <= request_in;
                end
            end

            assign fifo_entry[gen] = entry_q;
        end
    end

endmodule

//--- request_arbiter.sv
module request_arbiter
    import mem_packet_pkg::*;
(
    input  logic                  clk_in,
    input  logic                  reset_in,

    input  logic [num_ports-1:0]  head_valid,
    input  mem_request_t          heads [num_ports],
    output logic [num_ports-1:0]  pop,

    input  logic                  busy,
    output logic                  grant_valid,
    output mem_request_t          grant_request
);

    port_id_t last_grant;
    port_id_t sel_port;
    logic     can_grant;

    // The cycle that carries a grant may not start another one
    assign can_grant = ~busy & ~grant_valid & (|head_valid);

    always_comb
    begin
        if (&head_valid)
        begin
            sel_port = ~last_grant;                 // Both waiting so the other port goes
        end
        else if (head_valid[1])
        begin
            sel_port = 1'b1;
        end
        else
        begin
            sel_port = 1'b0;
        end
    end

    always_ff @(posedge clk_in, posedge reset_in)
    begin
        if (reset_in)
        begin
            grant_valid <= 1'b0;
            pop         <= '0;
            last_grant  <= 1'b1;                    // Port 0 wins the first tie
        end
        else
        begin
            grant_valid <= can_grant;
            pop         <= can_grant ? num_ports'(1) << sel_port : '0;
            if (can_grant)
            begin
                last_grant <= sel_port;
            end
        end
    end

    always_ff @(posedge clk_in)
    begin
        if (can_grant)
        begin
            grant_request <= heads[sel_port];
        end
    end

endmodule

//--- wb_master_bridge.sv
module wb_master_bridge
    import mem_packet_pkg::*;
    import wb_bus_pkg::*;
(
    input  logic           clk_in,
    input  logic           reset_in,

    input  logic           grant_valid,
    input  mem_request_t   grant_request,
    output logic           busy,

    output wb_m2s_t        wb_m2s,
    input  wb_s2m_t        wb_s2m,

    output mem_response_t  response,
    output logic           response_valid,
    input  logic           response_ack
);

    typedef enum logic [1:0]
    {
        st_idle,
        st_bus,
        st_respond
    } bridge_state_t;

    bridge_state_t            state;
    mem_request_t             req_q;
    logic [wb_data_width-1:0] data_q;

    always_ff @(posedge clk_in, posedge reset_in)
    begin
        if (reset_in)
        begin
            state <= st_idle;
        end
        else
        begin
            case (state)
                st_idle:    if (grant_valid)   state <= st_bus;
                st_bus:     if (wb_s2m.ack)    state <= st_respond;
                st_respond: if (response_ack)  state <= st_idle;     // Queue took the push
                default:                       state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk_in)
    begin
        if ((state == st_idle) & grant_valid)
        begin
            req_q <= grant_request;
        end
        if ((state == st_bus) & wb_s2m.ack)
        begin
            data_q <= req_q.write ? req_q.data : wb_s2m.dat;    // Writes echo their data
        end
    end

    assign busy = (state != st_idle);

    //////////////////////////////
    // Wishbone classic master
    //////////////////////////////

    // Respond state keeps cyc low between two transfers
    assign wb_m2s.cyc = (state == st_bus);
    assign wb_m2s.stb = (state == st_bus);
    assign wb_m2s.we  = req_q.write;
    assign wb_m2s.adr = req_q.addr;
    assign wb_m2s.dat = req_q.data;
    assign wb_m2s.sel = req_q.byte_sel;

    assign response.write = req_q.write;
    assign response.port  = req_q.port;
    assign response.tag   = req_q.tag;
    assign response.addr  = req_q.addr;
    assign response.data  = data_q;
    assign response_valid = (state == st_respond);

endmodule

//--- mem_access_top.sv
module mem_access_top
    import mem_packet_pkg::*;
    import wb_bus_pkg::*;
#(
    parameter int req_queue_size  = 16,
    parameter int req_ptr_width   = 4,
    parameter int resp_queue_size = 8,
    parameter int resp_ptr_width  = 3
)
(
    input  logic                  clk_in,
    input  logic                  reset_in,

    input  mem_request_t          request_in [num_ports],
    input  logic [num_ports-1:0]  request_valid_in,
    output logic [num_ports-1:0]  issue_ack_out,
    output logic [num_ports-1:0]  is_full_out,
    output logic [num_ports-1:0]  is_empty_out,

    output mem_response_t         response_out,
    output logic                  response_valid_out,
    input  logic                  response_ack_in,

    output wb_m2s_t               wb_m2s,
    input  wb_s2m_t               wb_s2m
);

    logic [num_ports-1:0] head_valid;
    mem_request_t         heads [num_ports];
    logic [num_ports-1:0] pop;

    logic                 busy;
    logic                 grant_valid;
    mem_request_t         grant_request;

    mem_response_t        response;
    logic                 response_valid;
    logic                 response_ack;

    for (genvar p = 0; p < num_ports; p++)
    begin : g_req_queue
        fifo_queue
        #(
            .entry_t            (mem_request_t),
            .queue_size         (req_queue_size),
            .queue_ptr_width    (req_ptr_width),
            .storage_type       ("LUTRAM")
        )
        i_req_queue
        (
            .clk_in             (clk_in),
            .reset_in           (reset_in),
            .is_empty_out       (is_empty_out[p]),
            .is_full_out        (is_full_out[p]),
            .request_in         (request_in[p]),
            .request_valid_in   (request_valid_in[p]),
            .issue_ack_out      (issue_ack_out[p]),
            .request_out        (heads[p]),
            .request_valid_out  (head_valid[p]),
            .issue_ack_in       (pop[p])
        );
    end

    request_arbiter i_request_arbiter
    (
        .clk_in         (clk_in),
        .reset_in       (reset_in),
        .head_valid     (head_valid),
        .heads          (heads),
        .pop            (pop),
        .busy           (busy),
        .grant_valid    (grant_valid),
        .grant_request  (grant_request)
    );

    wb_master_bridge i_wb_master_bridge
    (
        .clk_in         (clk_in),
        .reset_in       (reset_in),
        .grant_valid    (grant_valid),
        .grant_request  (grant_request),
        .busy           (busy),
        .wb_m2s         (wb_m2s),
        .wb_s2m         (wb_s2m),
        .response       (response),
        .response_valid (response_valid),
        .response_ack   (response_ack)
    );

    // Flip-flop storage here since the response queue is small
    fifo_queue
    #(
        .entry_t            (mem_response_t),
        .queue_size         (resp_queue_size),
        .queue_ptr_width    (resp_ptr_width),
        .storage_type       ("FlipFlop")
    )
    i_resp_queue
    (
        .clk_in             (clk_in),
        .reset_in           (reset_in),
        .is_empty_out       (),
        .is_full_out        (),
        .request_in         (response),
        .request_valid_in   (response_valid),
        .issue_ack_out      (response_ack),
        .request_out        (response_out),
        .request_valid_out  (response_valid_out),
        .issue_ack_in       (response_ack_in)
    );

endmodule

//--- tb_mem_access_properties.sv
module tb_mem_access_properties
    import mem_packet_pkg::*;
    import wb_bus_pkg::*;
#(
    parameter int queue_size = 16
)
(
    input  logic                  clk_in,
    input  logic                  reset_in,
    input  logic [num_ports-1:0]  request_valid_in,
    input  logic [num_ports-1:0]  issue_ack_out,
    input  logic [num_ports-1:0]  is_full_out,
    input  logic [num_ports-1:0]  is_empty_out,
    input  logic [num_ports-1:0]  pop,
    input  mem_response_t         response_out,
    input  logic                  response_valid_out,
    input  logic                  response_ack_in,
    input  wb_m2s_t               wb_m2s,
    input  wb_s2m_t               wb_s2m
);

    typedef struct packed
    {
        logic        we;
        logic [31:0] adr;
        logic [31:0] dat;
        logic [3:0]  sel;
    } bus_rec_t;

    int unsigned failures = 0;

    bus_rec_t    bus_log [32];                      // Bus transfers not yet answered
    logic [4:0]  log_wr;
    logic [4:0]  log_rd;
    logic [31:0] shadow_mem [16];
    tag_t        exp_tag [num_ports];
    logic        fair_pending;
    logic        last_bus_port;

    logic        resp_pop;
    bus_rec_t    head_rec;
    logic [3:0]  shadow_idx;
    logic [31:0] expected_data;
    tag_t        expected_tag;

    assign resp_pop      = response_valid_out & response_ack_in;
    assign head_rec      = bus_log[log_rd];
    assign shadow_idx    = {response_out.addr[31], response_out.addr[2:0]};
    assign expected_data = head_rec.we ? head_rec.dat : shadow_mem[shadow_idx];
    assign expected_tag  = exp_tag[response_out.port];

    function automatic logic [31:0] merge_bytes(logic [31:0] old_word, logic [31:0] new_word,
                                                logic [3:0] sel);
        logic [31:0] word;
        word = old_word;
        for (int b = 0; b < 4; b++)
        begin
            if (sel[b])
            begin
                word[8*b +: 8] = new_word[8*b +: 8];
            end
        end
        return word;
    endfunction

    always_ff @(posedge clk_in, posedge reset_in)
    begin
        if (reset_in)
        begin
            log_wr        <= '0;
            log_rd        <= '0;
            fair_pending  <= 1'b0;
            last_bus_port <= 1'b0;
            for (int p = 0; p < num_ports; p++)
            begin
                exp_tag[p] <= '0;
            end
            for (int i = 0; i < 16; i++)
            begin
                shadow_mem[i] <= '0;                // Memory model also starts at zero
            end
        end
        else
        begin
            if (wb_m2s.cyc & wb_s2m.ack)
            begin
                bus_log[log_wr] <= {wb_m2s.we, wb_m2s.adr, wb_m2s.dat, wb_m2s.sel};
                log_wr          <= log_wr + 5'd1;
                fair_pending    <= ~|is_empty_out;
                last_bus_port   <= wb_m2s.adr[31];
            end
            if (resp_pop)
            begin
                log_rd                     <= log_rd + 5'd1;
                exp_tag[response_out.port] <= expected_tag + 8'd1;
                if (response_out.write)
                begin
                    shadow_mem[shadow_idx] <= merge_bytes(shadow_mem[shadow_idx],
                                                          response_out.data, head_rec.sel);
                end
            end
        end
    end

    //////////////////////////////
    // Wishbone classic
    //////////////////////////////

    a_reset_idle: assert property (@(posedge clk_in) reset_in |->
        !wb_m2s.cyc && !wb_m2s.stb && issue_ack_out == '0 && !response_valid_out)
    else begin failures++; $error("Outputs active while reset is applied"); end

    a_stb_cyc: assert property (@(posedge clk_in) wb_m2s.stb == wb_m2s.cyc)
    else begin failures++; $error("[FAIL] %0t wb_m2s.stb expected %b observed %b",
        $time, $sampled(wb_m2s.cyc), $sampled(wb_m2s.stb)); end

    a_bus_stable: assert property (@(posedge clk_in) disable iff (reset_in)
        wb_m2s.cyc && !wb_s2m.ack |=> $stable({wb_m2s.we, wb_m2s.adr, wb_m2s.dat, wb_m2s.sel}))
    else begin failures++; $error("Bus request fields changed before ack"); end

    a_cyc_gap: assert property (@(posedge clk_in) disable iff (reset_in)
        wb_m2s.cyc && wb_s2m.ack |=> !wb_m2s.cyc)
    else begin failures++; $error("No idle cycle between two bus transfers"); end

    // Both clients waiting so the other port must own the next transfer
    a_fairness: assert property (@(posedge clk_in) disable iff (reset_in)
        $rose(wb_m2s.cyc) && fair_pending |-> wb_m2s.adr[31] != last_bus_port)
    else begin failures++; $error("[FAIL] %0t wb_m2s.adr[31] expected %b observed %b",
        $time, !$sampled(last_bus_port), $sampled(wb_m2s.adr[31])); end

    //////////////////////////////
    // Responses
    //////////////////////////////

    a_tag_order: assert property (@(posedge clk_in) disable iff (reset_in)
        resp_pop |-> response_out.tag == expected_tag)
    else begin failures++; $error("[FAIL] %0t response_out.tag expected %h observed %h",
        $time, $sampled(expected_tag), $sampled(response_out.tag)); end

    a_resp_write: assert property (@(posedge clk_in) disable iff (reset_in)
        resp_pop |-> response_out.write == head_rec.we)
    else begin failures++; $error("[FAIL] %0t response_out.write expected %b observed %b",
        $time, $sampled(head_rec.we), $sampled(response_out.write)); end

    a_resp_addr: assert property (@(posedge clk_in) disable iff (reset_in)
        resp_pop |-> response_out.addr == head_rec.adr)
    else begin failures++; $error("[FAIL] %0t response_out.addr expected %h observed %h",
        $time, $sampled(head_rec.adr), $sampled(response_out.addr)); end

    a_resp_data: assert property (@(posedge clk_in) disable iff (reset_in)
        resp_pop |-> response_out.data == expected_data)
    else begin failures++; $error("[FAIL] %0t response_out.data expected %h observed %h",
        $time, $sampled(expected_data), $sampled(response_out.data)); end

    a_resp_hold: assert property (@(posedge clk_in) disable iff (reset_in)
        response_valid_out && !response_ack_in |=> $stable(response_out))
    else begin failures++; $error("Response changed while it was held back"); end

    //////////////////////////////
    // Client handshake
    //////////////////////////////

    for (genvar p = 0; p < num_ports; p++)
    begin : g_port
        logic [5:0] pushes_held;                    // Acked pushes not yet popped

        always_ff @(posedge clk_in, posedge reset_in)
        begin
            if (reset_in)
            begin
                pushes_held <= '0;
            end
            else
            begin
                pushes_held <= pushes_held + 6'(issue_ack_out[p]) - 6'(pop[p]);
            end
        end

        a_ack_cause: assert property (@(posedge clk_in) disable iff (reset_in)
            issue_ack_out[p] |->
            $past(request_valid_in[p] & ~issue_ack_out[p] & (~is_full_out[p] | pop[p])))
        else begin failures++; $error("Port %0d acked a push it could not take", p); end

        a_ack_single: assert property (@(posedge clk_in) disable iff (reset_in)
            issue_ack_out[p] |=> !issue_ack_out[p])
        else begin failures++; $error("Port %0d ack high for two cycles", p); end

        a_full: assert property (@(posedge clk_in) disable iff (reset_in)
            pushes_held >= 6'(queue_size) |-> is_full_out[p])
        else begin failures++; $error("[FAIL] %0t is_full_out[%0d] expected 1 observed 0",
            $time, p); end

        // An acked push still counts while its ack is high
        a_empty: assert property (@(posedge clk_in) disable iff (reset_in)
            is_empty_out[p] == (pushes_held == 6'd0 && !issue_ack_out[p]))
        else begin failures++; $error("[FAIL] %0t is_empty_out[%0d] expected %b observed %b",
            $time, p, $sampled(pushes_held == 6'd0 && !issue_ack_out[p]),
            $sampled(is_empty_out[p])); end
    end

endmodule

bind mem_access_top tb_mem_access_properties
#(
    .queue_size         (req_queue_size)
)
i_mem_access_properties
(
    .clk_in             (clk_in),
    .reset_in           (reset_in),
    .request_valid_in   (request_valid_in),
    .issue_ack_out      (issue_ack_out),
    .is_full_out        (is_full_out),
    .is_empty_out       (is_empty_out),
    .pop                (pop),
    .response_out       (response_out),
    .response_valid_out (response_valid_out),
    .response_ack_in    (response_ack_in),
    .wb_m2s             (wb_m2s),
    .wb_s2m             (wb_s2m)
);

//--- tb_mem_access.sv
module tb_mem_access
    import mem_packet_pkg::*;
    import wb_bus_pkg::*;
();

    localparam int requests_per_port = 60;
    localparam int total_responses   = requests_per_port * num_ports;
    localparam int timeout_cycles    = total_responses * 30 + 1000;
    localparam int stall_start       = 150;
    localparam int stall_length      = 300;         // Long enough to fill every queue

    logic                 clk_in = 1'b0;
    logic                 reset_in;
    mem_request_t         request_in [num_ports];
    logic [num_ports-1:0] request_valid_in;
    logic [num_ports-1:0] issue_ack_out;
    logic [num_ports-1:0] is_full_out;
    logic [num_ports-1:0] is_empty_out;
    mem_response_t        response_out;
    logic                 response_valid_out;
    logic                 response_ack_in;
    wb_m2s_t              wb_m2s;
    wb_s2m_t              wb_s2m;

    logic [31:0] lfsr_state = 32'h66a7;
    int          issued [num_ports];
    tag_t        next_tag [num_ports];
    int          responses_seen;
    int          cycle_count = 0;
    logic [31:0] mem_model [16];                    // Byte lanes written through sel
    logic        mem_busy;
    int          mem_wait;

    mem_access_top i_mem_access_top
    (
        .clk_in             (clk_in),
        .reset_in           (reset_in),
        .request_in         (request_in),
        .request_valid_in   (request_valid_in),
        .issue_ack_out      (issue_ack_out),
        .is_full_out        (is_full_out),
        .is_empty_out       (is_empty_out),
        .response_out       (response_out),
        .response_valid_out (response_valid_out),
        .response_ack_in    (response_ack_in),
        .wb_m2s             (wb_m2s),
        .wb_s2m             (wb_s2m)
    );

    always #50 clk_in = ~clk_in;

    always @(posedge clk_in)
    begin
        cycle_count++;
    end

    function automatic logic [31:0] lfsr_next(logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // One LFSR step per bit handed out
    function automatic logic [31:0] take_bits(int n);
        logic [31:0] bits;
        bits = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr_state = lfsr_next(lfsr_state);
            bits       = {bits[30:0], lfsr_state[0]};
        end
        return bits;
    endfunction

    function automatic logic in_stall();
        return cycle_count >= stall_start && cycle_count < stall_start + stall_length;
    endfunction

    function automatic int unsigned check_failures();
        return i_mem_access_top.i_mem_access_properties.failures;
    endfunction

    task automatic drive_clients();
        for (int p = 0; p < num_ports; p++)
        begin
            if (issue_ack_out[p])
            begin
                request_valid_in[p] = 1'b0;
            end
            if (!request_valid_in[p] && issued[p] < requests_per_port
                && (in_stall() || take_bits(2) != 32'd0))
            begin
                request_in[p].write    = take_bits(1) == 32'd1;
                request_in[p].port     = port_id_t'(p);
                request_in[p].tag      = next_tag[p];
                request_in[p].byte_sel = 4'(take_bits(4));
                request_in[p].addr     = {p[0], 28'd0, 3'(take_bits(3))};  // Own region
                request_in[p].data     = take_bits(32);
                request_valid_in[p]    = 1'b1;
                next_tag[p]            = next_tag[p] + 8'd1;
                issued[p]++;
            end
        end
    endtask

    task automatic drive_memory();
        logic [3:0] idx;
        idx = {wb_m2s.adr[31], wb_m2s.adr[2:0]};
        if (wb_m2s.cyc && !wb_s2m.ack)
        begin
            if (!mem_busy)
            begin
                mem_busy = 1'b1;
                mem_wait = int'(take_bits(2));      // Ack delay of 0 to 3 cycles
            end
            if (mem_wait == 0)
            begin
                wb_s2m.ack = 1'b1;
                wb_s2m.dat = mem_model[idx];
                for (int b = 0; b < 4; b++)
                begin
                    if (wb_m2s.we && wb_m2s.sel[b])
                    begin
                        mem_model[idx][8*b +: 8] = wb_m2s.dat[8*b +: 8];
                    end
                end
                mem_busy = 1'b0;
            end
            else
            begin
                mem_wait--;
            end
        end
        else
        begin
            wb_s2m.ack = 1'b0;
        end
    endtask

    task automatic drive_response_ack();
        if (response_valid_out && !response_ack_in && !in_stall() && take_bits(2) != 32'd0)
        begin
            response_ack_in = 1'b1;
            responses_seen++;
        end
        else
        begin
            response_ack_in = 1'b0;
        end
    endtask

    always @(negedge clk_in)
    begin
        if (!reset_in)
        begin
            drive_clients();
            drive_memory();
            drive_response_ack();
        end
    end

    initial
    begin
        reset_in         <= 1'b1;
        request_valid_in = '0;
        response_ack_in  = 1'b0;
        wb_s2m           = '0;
        responses_seen   = 0;
        mem_busy         = 1'b0;
        mem_wait         = 0;
        for (int p = 0; p < num_ports; p++)
        begin
            request_in[p] = '0;
            issued[p]     = 0;
            next_tag[p]   = '0;
        end
        for (int i = 0; i < 16; i++)
        begin
            mem_model[i] = '0;
        end
        repeat (2) @(posedge clk_in);
        @(negedge clk_in);
        reset_in <= 1'b0;

        while (responses_seen < total_responses && cycle_count < timeout_cycles
               && check_failures() == 0)
        begin
            @(negedge clk_in);
        end
        if (responses_seen == total_responses)
        begin
            repeat (4) @(negedge clk_in);           // Let the last response checks fire
        end

        if (responses_seen == total_responses && check_failures() == 0)
        begin
            $display("*** PASSED ***");
            $finish;
        end
        else
        begin
            if (check_failures() == 0)
            begin
                $display("Timeout after %0d cycles with %0d of %0d responses",
                         cycle_count, responses_seen, total_responses);
            end
            $display("*** FAILED ***");
            $fatal(1, "Simulation stopped on error");
        end
    end

endmodule

//--- build.f
mem_packet_pkg.sv
wb_bus_pkg.sv
single_port_lutram.sv
fifo_queue.sv
request_arbiter.sv
wb_master_bridge.sv
mem_access_top.sv
tb_mem_access_properties.sv
tb_mem_access.sv

//--- run.sh
#!/bin/sh
verilator --binary --timing --assert --top-module tb_mem_access -f build.f -o sim_tb \
    && ./obj_dir/sim_tb +verilator+error+limit+1000 | tee /dev/stderr \
    | grep -qF '*** PASSED ***' \
    && echo "Simulation run succeeded" \
    || { echo "Simulation run did not succeed"; exit 1; }
